// ==== bench/tb_dcache.sv ====
`timescale 1ns/100ps
`include "dcache_defines.svh"

module tb_dcache
    import dcache_pkg::*;
    import dcache_bus_pkg::*;
();

    localparam int num_requests    = 51;
    // Lookup, write-back and refill with the slowest memory answer
    localparam int max_miss_cycles = 20;
    localparam int timeout_cycles  = 20 * num_requests * max_miss_cycles;

    logic      clk_i;
    logic      rst_i;
    logic      p_strobe_i;
    proc_req_t p_req_i;
    dc_word_t  p_rdata_o;
    logic      p_ready_o;
    logic      m_strobe_o;
    mem_req_t  m_req_o;
    dc_line_t  m_rdata_i;
    logic      m_ready_i;

    // Reference copy of the cache state
    dc_tag_t   ref_tag   [`DC_SETS][`DC_WAYS];
    logic      ref_valid [`DC_SETS][`DC_WAYS];
    logic      ref_dirty [`DC_SETS][`DC_WAYS];
    dc_plru_t  ref_plru  [`DC_SETS];
    // Architectural words, and the backing store by line address
    dc_word_t  shadow    [bit [31:0]];
    dc_line_t  mem_lines [bit [31:0]];
    // Memory transfers of the current request
    mem_req_t  mem_log   [$];

    logic        last_hit;
    logic        last_wb;
    int          last_way;
    logic [31:0] last_wb_addr;
    int          last_lat;
    int          check_cnt = 0;
    int          err_cnt   = 0;
    int          proto_err = 0;
    logic [31:0] lfsr_q    = 32'hf064d9b9;
    logic        m_strobe_prev;
    logic        p_ready_prev;

    dcache_top i_dut (
        .clk_i, .rst_i, .p_strobe_i, .p_req_i, .p_rdata_o, .p_ready_o,
        .m_strobe_o, .m_req_o, .m_rdata_i, .m_ready_i
    );

    initial
    begin
        clk_i = 1'b0;
        forever
            #5 clk_i = ~clk_i;
    end

    // ==================================================
    // Helpers
    // ==================================================

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_q = lfsr_q[0] ? (lfsr_q >> 1) ^ 32'h8020_0003 : lfsr_q >> 1;
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // Untouched memory differs for every word address
    function automatic dc_word_t fill_word(input logic [31:0] addr);
        return {addr[15:0], addr[31:16]} ^ 32'ha5c3_0f96;
    endfunction

    function automatic dc_word_t shadow_word(input logic [31:0] addr);
        logic [31:0] wa;
        wa = {addr[31:2], 2'b00};
        if (shadow.exists(wa))
            return shadow[wa];
        return fill_word(wa);
    endfunction

    // Word 0 in the top bits
    function automatic dc_line_t shadow_line(input logic [31:0] line_addr);
        dc_line_t l;
        for (int w = 0; w < 4; w++)
            l[(3 - w) * 32 +: 32] = shadow_word(line_addr + 32'(4 * w));
        return l;
    endfunction

    function automatic dc_line_t memory_line(input logic [31:0] line_addr);
        dc_line_t l;
        if (mem_lines.exists(line_addr))
            return mem_lines[line_addr];
        for (int w = 0; w < 4; w++)
            l[(3 - w) * 32 +: 32] = fill_word(line_addr + 32'(4 * w));
        return l;
    endfunction

    function automatic dc_word_t merge_bytes(input dc_word_t old, input dc_word_t wdata,
                                             input logic [3:0] be);
        dc_word_t n;
        for (int b = 0; b < 4; b++)
            n[8*b +: 8] = be[b] ? wdata[8*b +: 8] : old[8*b +: 8];
        return n;
    endfunction

    // Tree walk with bit 0 for the half, bit 1 for ways 0/1 and bit 2 for ways 2/3
    function automatic int victim_of(input dc_plru_t b);
        if (!b[0])
            return b[1] ? 1 : 0;
        return b[2] ? 3 : 2;
    endfunction

    // Point the tree away from the touched way
    function automatic dc_plru_t touched(input dc_plru_t b, input int way);
        case (way)
            0:       return {b[2], 2'b11};
            1:       return {b[2], 2'b01};
            2:       return {1'b1, b[1], 1'b0};
            default: return {1'b0, b[1], 1'b0};
        endcase
    endfunction

    function automatic logic [31:0] make_addr(input int tag, input int idx, input int wofs);
        dc_addr_u a;
        a.fld.tag      = dc_tag_t'(tag);
        a.fld.index    = dc_index_t'(idx);
        a.fld.word_ofs = dc_word_ofs_t'(wofs);
        a.fld.byte_ofs = '0;
        return a.raw;
    endfunction

    task automatic check(input logic cond, input string what);
        check_cnt++;
        assert (cond)
        else
        begin
            err_cnt++;
            $display("error %0t: %s", $time, what);
        end
    endtask

    task automatic protocol_check(input logic cond, input string what);
        check(cond, what);
        if (!cond)
            proto_err++;
    endtask

    task automatic report_test(input int num, input string name, input int errs);
        if (errs == 0)
            $display("test %0d %s: ok", num, name);
        else
            $display("test %0d %s: %0d errors", num, name, errs);
    endtask

    // ==================================================
    // One request with reference prediction
    // ==================================================

    task automatic access(input logic rw, input logic [3:0] be, input logic [31:0] addr,
                          input dc_word_t wdata);
        dc_addr_u    a;
        int          idx;
        int          way;
        int          n;
        logic        hit;
        logic        wb;
        logic        ready;
        int          lat;
        logic [31:0] wb_addr;
        logic [31:0] line_addr;
        dc_line_t    wb_line;
        dc_word_t    exp_word;
        dc_word_t    got;
        a.raw     = addr;
        idx       = int'(a.fld.index);
        line_addr = {addr[31:4], 4'h0};
        hit       = 1'b0;
        way       = 0;
        wb        = 1'b0;
        wb_addr   = '0;
        wb_line   = '0;
        for (int w = 0; w < `DC_WAYS; w++)
        begin
            if (ref_valid[idx][w] && ref_tag[idx][w] == a.fld.tag)
            begin
                hit = 1'b1;
                way = w;
            end
        end
        // Miss takes the pLRU victim and writes it back first when dirty
        if (!hit)
        begin
            way     = victim_of(ref_plru[idx]);
            wb      = ref_valid[idx][way] && ref_dirty[idx][way];
            wb_addr = {ref_tag[idx][way], a.fld.index, 4'h0};
            wb_line = shadow_line(wb_addr);
        end
        exp_word = rw ? '0 : shadow_word(addr);
        mem_log.delete();

        @(posedge clk_i);
        #1;
        p_req_i.rw       = rw;
        p_req_i.byte_en  = be;
        p_req_i.addr.raw = addr;
        p_req_i.wdata    = wdata;
        p_strobe_i       = 1'b1;
        lat   = 0;
        ready = 1'b0;
        got   = '0;
        while (!ready)
        begin
            @(posedge clk_i);
            lat++;
            ready = p_ready_o;
            got   = p_rdata_o;
            #1;
            p_strobe_i = 1'b0;
        end

        n = mem_log.size();
        if (hit)
        begin
            check(lat == 2, $sformatf("hit at %h took %0d cycles, expected 2", addr, lat));
            check(n == 0, $sformatf("hit at %h went to memory", addr));
        end
        else
        begin
            check(n == (wb ? 2 : 1), $sformatf("miss at %h made %0d transfers", addr, n));
            if (n == (wb ? 2 : 1))
            begin
                if (wb)
                    check(mem_log[0].rw && mem_log[0].addr.raw == wb_addr
                          && mem_log[0].wline == wb_line,
                          $sformatf("write-back of line %h has wrong request", wb_addr));
                check(!mem_log[n-1].rw && mem_log[n-1].addr.raw == line_addr,
                      $sformatf("refill of line %h has wrong request", line_addr));
            end
        end
        check(got == exp_word,
              $sformatf("data at %h is %h, expected %h", addr, got, exp_word));

        if (!hit)
        begin
            ref_tag[idx][way]   = a.fld.tag;
            ref_valid[idx][way] = 1'b1;
            ref_dirty[idx][way] = rw;
        end
        else if (rw)
            ref_dirty[idx][way] = 1'b1;
        ref_plru[idx] = touched(ref_plru[idx], way);
        if (rw)
            shadow[{addr[31:2], 2'b00}] = merge_bytes(shadow_word(addr), wdata, be);
        // What the DUT did on its memory port
        last_hit     = (n == 0);
        last_wb      = (n == 2 && mem_log[0].rw);
        last_way     = way;
        last_wb_addr = wb_addr;
        last_lat     = lat;
    endtask

    // ==================================================
    // Memory model and protocol monitor
    // ==================================================

    initial
    begin : memory_model
        mem_req_t req;
        int       delay;
        m_ready_i = 1'b0;
        m_rdata_i = '0;
        forever
        begin
            @(posedge clk_i);
            if (!rst_i && m_strobe_o)
            begin
                req = m_req_o;
                mem_log.push_back(req);
                delay = 1 + int'(rand_bits(3) % 6);
                for (int i = 0; i < delay; i++)
                begin
                    @(posedge clk_i);
                    protocol_check(m_req_o == req, "m_req_o changed before m_ready_i");
                end
                #1;
                if (req.rw)
                    mem_lines[req.addr.raw] = req.wline;
                else
                    m_rdata_i = memory_line(req.addr.raw);
                m_ready_i = 1'b1;
                @(posedge clk_i);
                protocol_check(m_req_o == req, "m_req_o changed in the m_ready_i cycle");
                #1;
                m_ready_i = 1'b0;
                m_rdata_i = '0;
            end
        end
    end

    // Strobes and ready are single-cycle pulses
    always @(posedge clk_i)
    begin
        if (rst_i)
        begin
            m_strobe_prev = 1'b0;
            p_ready_prev  = 1'b0;
        end
        else
        begin
            if (m_strobe_o)
                protocol_check(!m_strobe_prev, "m_strobe_o held for two cycles");
            if (p_ready_o)
                protocol_check(!p_ready_prev, "p_ready_o held for two cycles");
            m_strobe_prev = m_strobe_o;
            p_ready_prev  = p_ready_o;
        end
    end

    initial
    begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < timeout_cycles)
        begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout: run still going after %0d cycles", cycles);
        $display("Result: FAILED");
        $finish;
    end

    // ==================================================
    // Tests
    // ==================================================

    initial
    begin : main
        int          errs;
        int          fill_ways [5];
        int          exp_ways  [5];
        logic [31:0] addr;
        logic [31:0] evicted   [2];
        logic [3:0]  be;
        dc_word_t    wd;
        logic        rw;
        exp_ways   = '{0, 2, 1, 3, 0};
        p_strobe_i = 1'b0;
        p_req_i    = '0;
        rst_i      = 1'b1;
        for (int s = 0; s < `DC_SETS; s++)
        begin
            ref_plru[s] = '0;
            for (int w = 0; w < `DC_WAYS; w++)
            begin
                ref_tag[s][w]   = '0;
                ref_valid[s][w] = 1'b0;
                ref_dirty[s][w] = 1'b0;
            end
        end
        repeat (8) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        @(posedge clk_i);
        protocol_check(!p_ready_o && !m_strobe_o, "p_ready_o or m_strobe_o high after reset");

        // Miss fills the line, then two hits in it
        errs = err_cnt;
        access(1'b0, 4'h0, make_addr(4, 35, 1), '0);
        access(1'b0, 4'h0, make_addr(4, 35, 1), '0);
        check(last_hit && last_lat == 2, "second read of a line did not hit");
        access(1'b0, 4'h0, make_addr(4, 35, 2), '0);
        report_test(1, "read miss then hit", err_cnt - errs);

        // Byte merge on hits
        errs = err_cnt;
        for (int i = 0; i < 4; i++)
        begin
            be = 4'(rand_bits(4));
            wd = rand_bits(32);
            access(1'b1, be, make_addr(4, 35, i), wd);
            check(last_hit, "write to a cached line missed");
            access(1'b0, 4'h0, make_addr(4, 35, i), '0);
        end
        report_test(2, "write hit", err_cnt - errs);

        errs = err_cnt;
        access(1'b1, 4'(rand_bits(4)), make_addr(9, 36, 2), rand_bits(32));
        check(!last_hit && !last_wb, "write to an empty set was not a clean miss");
        access(1'b0, 4'h0, make_addr(9, 36, 2), '0);
        check(last_hit, "read after write miss did not hit");
        report_test(3, "write miss", err_cnt - errs);

        // Five tags into one empty set
        errs = err_cnt;
        for (int t = 0; t < 5; t++)
        begin
            access(1'b0, 4'h0, make_addr(t + 1, 20, 0), '0);
            fill_ways[t] = last_way;
            check(fill_ways[t] == exp_ways[t],
                  $sformatf("fill %0d predicted into way %0d", t, fill_ways[t]));
        end
        access(1'b0, 4'h0, make_addr(1, 20, 0), '0);
        check(!last_hit, "evicted tag still hit");
        report_test(4, "replacement order", err_cnt - errs);

        // Fill a set with dirty lines, then push two out
        errs = err_cnt;
        for (int i = 0; i < 6; i++)
        begin
            access(1'b1, 4'(rand_bits(4)), make_addr(10 + i, 45, 1), rand_bits(32));
            if (i >= 4)
            begin
                check(last_wb, "full dirty set gave no write-back");
                evicted[i-4] = last_wb_addr;
            end
        end
        for (int k = 0; k < 2; k++)
            access(1'b0, 4'h0, evicted[k] + 32'd4, '0);
        report_test(5, "dirty eviction", err_cnt - errs);

        // Mixed traffic over two sets keeps the monitors busy
        errs = err_cnt;
        for (int i = 0; i < 24; i++)
        begin
            rw   = 1'(rand_bits(1));
            be   = 4'(rand_bits(4));
            wd   = rand_bits(32);
            addr = make_addr(int'(rand_bits(3)), 3 + int'(rand_bits(1)), int'(rand_bits(2)));
            access(rw, be, addr, wd);
        end
        report_test(6, "random traffic and protocol", err_cnt - errs + proto_err);

        $display("checks: %0d passed, %0d failed", check_cnt - err_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_bus_pkg.sv
verilog/dcache_merge.sv
verilog/dcache_plru.sv
verilog/dcache_data.sv
verilog/dcache_tags.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
bench/tb_dcache.sv

// ==== verilog/dcache_bus_pkg.sv ====
`include "dcache_defines.svh"

package dcache_bus_pkg;

    import dcache_pkg::*;

    // ==================================================
    // Processor side, one word per request
    // ==================================================

    typedef struct packed {
        // 0 read, 1 write
        logic                     rw;
        logic [`DC_XLEN/8-1:0]    byte_en;
        dc_addr_u                 addr;
        dc_word_t                 wdata;
    } proc_req_t;

    // ==================================================
    // Memory side, whole lines only
    // ==================================================

    typedef struct packed {
        // 1 for victim write-back
        logic                     rw;
        // Always line aligned
        dc_addr_u                 addr;
        dc_line_t                 wline;
    } mem_req_t;

endpackage

// ==== verilog/dcache_ctrl.sv ====
`timescale 1ns/100ps

module dcache_ctrl
    import dcache_pkg::*;
    import dcache_bus_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    // Processor port
    input  logic      p_strobe_i,
    input  proc_req_t p_req_i,
    output dc_word_t  p_rdata_o,
    output logic      p_ready_o,
    // Memory port
    output logic      m_strobe_o,
    output mem_req_t  m_req_o,
    input  dc_line_t  m_rdata_i,
    input  logic      m_ready_i,
    // Lookup
    output dc_index_t index_o,
    output dc_tag_t   tag_o,
    input  logic      hit_i,
    input  dc_way_t   hit_way_i,
    input  dc_way_t   victim_way_i,
    input  dc_tag_t   victim_tag_i,
    input  logic      victim_dirty_i,
    // Line storage
    input  dc_line_t  line_rd_i,
    output dc_way_t   line_sel_way_o,
    output logic      line_we_o,
    output dc_way_t   wr_way_o,
    output dc_line_t  wr_line_o,
    output logic      set_dirty_o,
    output logic      fill_o,
    output logic      touch_o,
    // Merge path
    output dc_line_t  merge_src_o,
    output proc_req_t merge_req_o,
    input  dc_line_t  merged_line_i,
    input  dc_word_t  rd_word_i
);

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_writeback,
        st_fill,
        st_fill_done
    } state_t;

    state_t    state_q;
    state_t    state_nxt;
    proc_req_t req_q;
    dc_line_t  fill_q;
    dc_way_t   victim_q;
    logic      sent_q;
    logic      issue;
    dc_addr_u  line_addr;
    mem_req_t  m_req_q;

    // ==================================================
    // Request FSM
    // ==================================================

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            state_q <= st_idle;
        else
            state_q <= state_nxt;
    end

    always_comb
    begin
        state_nxt = state_q;
        case (state_q)
            st_idle:
                if (p_strobe_i)
                    state_nxt = st_lookup;
            st_lookup:
                if (hit_i)
                    state_nxt = st_idle;
                else
                    // Dirty victim goes out before the refill
                    state_nxt = victim_dirty_i ? st_writeback : st_fill;
            st_writeback:
                if (m_ready_i)
                    state_nxt = st_fill;
            st_fill:
                if (m_ready_i)
                    state_nxt = st_fill_done;
            default:
                state_nxt = st_idle;
        endcase
    end

    // Request captured at the accepted strobe
    always_ff @(posedge clk_i)
    begin
        if (state_q == st_idle && p_strobe_i)
            req_q <= p_req_i;
        // Victim from current pLRU bits, held through refill
        if (state_q == st_lookup)
            victim_q <= victim_way_i;
        if (state_q == st_fill && m_ready_i)
            fill_q <= m_rdata_i;
    end

    // Live index in the strobe cycle so the RAMs answer in LOOKUP
    assign index_o = (state_q == st_idle && p_strobe_i) ? p_req_i.addr.fld.index
                                                         : req_q.addr.fld.index;
    assign tag_o   = req_q.addr.fld.tag;

    // ==================================================
    // Memory port
    // ==================================================

    // Line address of the victim or of the missing line
    always_comb
    begin
        line_addr.fld.tag      = (state_q == st_writeback) ? victim_tag_i : req_q.addr.fld.tag;
        line_addr.fld.index    = req_q.addr.fld.index;
        line_addr.fld.word_ofs = '0;
        line_addr.fld.byte_ofs = '0;
    end

    // One transfer per WRITEBACK or FILL visit
    assign issue = (state_q == st_writeback || state_q == st_fill) && !sent_q;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            m_strobe_o <= 1'b0;
            sent_q     <= 1'b0;
        end
        else
        begin
            m_strobe_o <= issue;
            if (issue)
                sent_q <= 1'b1;
            else if (m_ready_i)
                sent_q <= 1'b0;
        end
    end

    // Held from the strobe until m_ready_i
    always_ff @(posedge clk_i)
    begin
        if (issue)
        begin
            m_req_q.rw    <= (state_q == st_writeback);
            m_req_q.addr  <= line_addr;
            m_req_q.wline <= (state_q == st_writeback) ? line_rd_i : '0;
        end
    end

    assign m_req_o = m_req_q;

    // ==================================================
    // Cache updates and processor response
    // ==================================================

    // Hit way in LOOKUP, victim way otherwise
    assign line_sel_way_o = (state_q == st_lookup) ? hit_way_i : victim_q;
    assign wr_way_o       = line_sel_way_o;

    assign merge_src_o = (state_q == st_fill_done) ? fill_q : line_rd_i;
    assign merge_req_o = req_q;

    assign fill_o      = (state_q == st_fill_done);
    assign line_we_o   = (state_q == st_lookup && hit_i && req_q.rw) || fill_o;
    assign set_dirty_o = req_q.rw;
    // Raw refill for reads, merged line for writes
    assign wr_line_o   = (fill_o && !req_q.rw) ? fill_q : merged_line_i;

    assign p_ready_o = (state_q == st_lookup && hit_i) || fill_o;
    assign touch_o   = p_ready_o;
    assign p_rdata_o = (p_ready_o && !req_q.rw) ? rd_word_i : '0;

endmodule

// ==== verilog/dcache_data.sv ====
`timescale 1ns/100ps
`include "dcache_defines.svh"

module dcache_data
    import dcache_pkg::*;
(
    input  logic      clk_i,
    input  dc_index_t index_i,
    input  logic      we_i,
    input  dc_way_t   wr_way_i,
    input  dc_line_t  wr_line_i,
    input  dc_way_t   sel_way_i,
    output dc_line_t  line_o
);

    // Line RAM per way
    dc_line_t line_ram [`DC_WAYS][`DC_SETS];
    // All ways read every cycle
    dc_line_t line_rd  [`DC_WAYS];

    // ==================================================
    // Synchronous read, old data on a same-cycle write
    // ==================================================

    always_ff @(posedge clk_i)
    begin
        for (int w = 0; w < `DC_WAYS; w++)
        begin
            if (we_i && wr_way_i == dc_way_t'(w))
                line_ram[w][index_i] <= wr_line_i;
            line_rd[w] <= line_ram[w][index_i];
        end
    end

    // Hit way or victim, picked by the controller
    assign line_o = line_rd[sel_way_i];

endmodule

// ==== verilog/dcache_defines.svh ====
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// ==================================================
// Cache geometry
// ==================================================

// Processor word width
`define DC_XLEN        32
// One line moves as a single memory transfer
`define DC_LINE_BITS   128
// Associativity
`define DC_WAYS        4
// Number of sets
`define DC_SETS        64

// ==================================================
// Derived address field widths
// ==================================================

// Byte within a word
`define DC_BYTE_OFS    $clog2(`DC_XLEN / 8)
// Word within a line
`define DC_WORD_OFS    $clog2(`DC_LINE_BITS / `DC_XLEN)
// Set index
`define DC_INDEX_BITS  $clog2(`DC_SETS)
// Tag is whatever is left of the address
`define DC_TAG_BITS    (`DC_XLEN - `DC_INDEX_BITS - `DC_WORD_OFS - `DC_BYTE_OFS)
// Way number
`define DC_WAY_BITS    $clog2(`DC_WAYS)

`endif

// ==== verilog/dcache_merge.sv ====
`timescale 1ns/100ps

module dcache_merge
    import dcache_pkg::*;
    import dcache_bus_pkg::*;
(
    input  dc_line_t  src_line_i,
    input  proc_req_t req_i,
    output dc_word_t  rd_word_o,
    output dc_line_t  line_o
);

    localparam int word_bits  = $bits(dc_word_t);
    localparam int line_words = $bits(dc_line_t) / word_bits;

    int       base;
    dc_word_t old_word;
    dc_word_t new_word;

    // ==================================================
    // Word select, word 0 in the top bits
    // ==================================================

    always_comb
    begin
        base     = (line_words - 1 - int'(req_i.addr.fld.word_ofs)) * word_bits;
        old_word = src_line_i[base +: word_bits];
    end

    // Byte lanes taken in place from the write data
    always_comb
    begin
        for (int b = 0; b < word_bits / 8; b++)
        begin
            if (req_i.byte_en[b])
                new_word[8*b +: 8] = req_i.wdata[8*b +: 8];
            else
                new_word[8*b +: 8] = old_word[8*b +: 8];
        end
    end

    // Other words pass unchanged
    always_comb
    begin
        line_o                   = src_line_i;
        line_o[base +: word_bits] = new_word;
    end

    assign rd_word_o = old_word;

endmodule

// ==== verilog/dcache_pkg.sv ====
`include "dcache_defines.svh"

package dcache_pkg;

    // ==================================================
    // Scalar geometry types
    // ==================================================

    typedef logic [`DC_TAG_BITS-1:0]   dc_tag_t;
    typedef logic [`DC_INDEX_BITS-1:0] dc_index_t;
    typedef logic [`DC_WORD_OFS-1:0]   dc_word_ofs_t;
    typedef logic [`DC_WAY_BITS-1:0]   dc_way_t;
    typedef logic [`DC_XLEN-1:0]       dc_word_t;

    // Word 0 sits in the top bits of the line
    typedef logic [`DC_LINE_BITS-1:0]  dc_line_t;

    // ==================================================
    // Address views
    // ==================================================

    // Field view, MSB first
    typedef struct packed {
        dc_tag_t                 tag;
        dc_index_t               index;
        dc_word_ofs_t            word_ofs;
        logic [`DC_BYTE_OFS-1:0] byte_ofs;
    } dc_addr_fields_t;

    // Raw for the ports, fields for lookup and compare
    typedef union packed {
        logic [`DC_XLEN-1:0] raw;
        dc_addr_fields_t     fld;
    } dc_addr_u;

    // Tree bits of one set
    // Bit 0 picks the half, bit 1 ways 0/1, bit 2 ways 2/3
    typedef logic [2:0] dc_plru_t;

endpackage

// ==== verilog/dcache_plru.sv ====
`timescale 1ns/100ps
`include "dcache_defines.svh"

module dcache_plru
    import dcache_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  dc_index_t index_i,
    input  logic      touch_i,
    input  dc_way_t   way_i,
    output dc_way_t   victim_o
);

    dc_plru_t plru_q [`DC_SETS];
    dc_plru_t cur;

    assign cur = plru_q[index_i];

    // ==================================================
    // Victim walk down the tree
    // ==================================================

    always_comb
    begin
        if (!cur[0])
            victim_o = cur[1] ? dc_way_t'(1) : dc_way_t'(0);
        else
            victim_o = cur[2] ? dc_way_t'(3) : dc_way_t'(2);
    end

    // Point the tree away from the touched way
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int s = 0; s < `DC_SETS; s++)
                plru_q[s] <= '0;
        end
        else if (touch_i)
        begin
            // Left half touched, look right next time
            plru_q[index_i][0] <= !way_i[1];
            if (!way_i[1])
                plru_q[index_i][1] <= !way_i[0];
            else
                plru_q[index_i][2] <= !way_i[0];
        end
    end

endmodule

// ==== verilog/dcache_tags.sv ====
`timescale 1ns/100ps
`include "dcache_defines.svh"

module dcache_tags
    import dcache_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  dc_index_t index_i,
    input  dc_tag_t   tag_i,
    input  logic      we_i,
    input  dc_way_t   wr_way_i,
    input  logic      fill_i,
    input  logic      set_dirty_i,
    input  dc_way_t   victim_way_i,
    output logic      hit_o,
    output dc_way_t   hit_way_o,
    output dc_tag_t   victim_tag_o,
    output logic      victim_dirty_o
);

    // Tag RAM per way, synchronous read
    dc_tag_t                tag_ram [`DC_WAYS][`DC_SETS];
    dc_tag_t                tag_rd  [`DC_WAYS];
    // Status bits as flops so reset clears them at once
    logic [`DC_WAYS-1:0]    valid_q [`DC_SETS];
    logic [`DC_WAYS-1:0]    dirty_q [`DC_SETS];
    // Index of the last read, lines status up with tag_rd
    dc_index_t              rd_index_q;
    logic [`DC_WAYS-1:0]    way_hit;

    always_ff @(posedge clk_i)
    begin
        for (int w = 0; w < `DC_WAYS; w++)
        begin
            if (we_i && fill_i && wr_way_i == dc_way_t'(w))
                tag_ram[w][index_i] <= tag_i;
            tag_rd[w] <= tag_ram[w][index_i];
        end
        rd_index_q <= index_i;
    end

    // ==================================================
    // Valid and dirty flops
    // ==================================================

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            for (int s = 0; s < `DC_SETS; s++)
            begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end
        else if (we_i)
        begin
            // Write hit only touches dirty
            dirty_q[index_i][wr_way_i] <= set_dirty_i;
            if (fill_i)
                valid_q[index_i][wr_way_i] <= 1'b1;
        end
    end

    // Compare all valid ways, at most one matches
    always_comb
    begin
        hit_way_o = '0;
        for (int w = 0; w < `DC_WAYS; w++)
        begin
            way_hit[w] = valid_q[rd_index_q][w] && (tag_rd[w] == tag_i);
            if (way_hit[w])
                hit_way_o = dc_way_t'(w);
        end
    end

    assign hit_o          = |way_hit;
    assign victim_tag_o   = tag_rd[victim_way_i];
    assign victim_dirty_o = valid_q[rd_index_q][victim_way_i] && dirty_q[rd_index_q][victim_way_i];

endmodule

// ==== verilog/dcache_top.sv ====
`timescale 1ns/100ps

module dcache_top
    import dcache_pkg::*;
    import dcache_bus_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    // Processor side
    input  logic      p_strobe_i,
    input  proc_req_t p_req_i,
    output dc_word_t  p_rdata_o,
    output logic      p_ready_o,
    // Memory side
    output logic      m_strobe_o,
    output mem_req_t  m_req_o,
    input  dc_line_t  m_rdata_i,
    input  logic      m_ready_i
);

    // ==================================================
    // Controller to datapath wiring
    // ==================================================

    dc_index_t index;
    dc_tag_t   tag;
    logic      hit;
    dc_way_t   hit_way;
    dc_way_t   victim_way;
    dc_tag_t   victim_tag;
    logic      victim_dirty;
    dc_line_t  line_rd;
    dc_way_t   line_sel_way;
    logic      line_we;
    dc_way_t   wr_way;
    dc_line_t  wr_line;
    logic      set_dirty;
    logic      fill;
    logic      touch;
    dc_line_t  merge_src;
    proc_req_t merge_req;
    dc_line_t  merged_line;
    dc_word_t  rd_word;

    dcache_ctrl i_ctrl (
        .clk_i, .rst_i, .p_strobe_i, .p_req_i, .p_rdata_o, .p_ready_o,
        .m_strobe_o, .m_req_o, .m_rdata_i, .m_ready_i,
        .index_o(index), .tag_o(tag), .hit_i(hit), .hit_way_i(hit_way),
        .victim_way_i(victim_way), .victim_tag_i(victim_tag),
        .victim_dirty_i(victim_dirty), .line_rd_i(line_rd),
        .line_sel_way_o(line_sel_way), .line_we_o(line_we), .wr_way_o(wr_way),
        .wr_line_o(wr_line), .set_dirty_o(set_dirty), .fill_o(fill),
        .touch_o(touch), .merge_src_o(merge_src), .merge_req_o(merge_req),
        .merged_line_i(merged_line), .rd_word_i(rd_word)
    );

    // Tag and data writes share one enable
    dcache_tags i_tags (
        .clk_i, .rst_i, .index_i(index), .tag_i(tag), .we_i(line_we),
        .wr_way_i(wr_way), .fill_i(fill), .set_dirty_i(set_dirty),
        .victim_way_i(victim_way), .hit_o(hit), .hit_way_o(hit_way),
        .victim_tag_o(victim_tag), .victim_dirty_o(victim_dirty)
    );

    dcache_data i_data (
        .clk_i, .index_i(index), .we_i(line_we), .wr_way_i(wr_way),
        .wr_line_i(wr_line), .sel_way_i(line_sel_way), .line_o(line_rd)
    );

    // Touched way is the written way
    dcache_plru i_plru (
        .clk_i, .rst_i, .index_i(index), .touch_i(touch), .way_i(wr_way),
        .victim_o(victim_way)
    );

    dcache_merge i_merge (
        .src_line_i(merge_src), .req_i(merge_req), .rd_word_o(rd_word),
        .line_o(merged_line)
    );

endmodule
